// File: pot_pkg.sv
package pot_pkg;

    // scanned pots and reading width
    localparam int NUM_POTS = 12;
    localparam int VALUE_W  = 10;
    localparam int INDEX_W  = 4;

    // ADC channel of each effect parameter
    localparam logic [INDEX_W-1:0] POT_VOLUME           = 4'd0;
    localparam logic [INDEX_W-1:0] POT_REVERB_FEEDBACK  = 4'd1;
    localparam logic [INDEX_W-1:0] POT_PITCH            = 4'd2;
    localparam logic [INDEX_W-1:0] POT_REVERB_SIZE      = 4'd3;
    localparam logic [INDEX_W-1:0] POT_CRUSH_PRESSURE   = 4'd4;
    localparam logic [INDEX_W-1:0] POT_REVERB_WET       = 4'd5;
    localparam logic [INDEX_W-1:0] POT_DISTORTION_DRIVE = 4'd6;
    localparam logic [INDEX_W-1:0] POT_DELAY_FEEDBACK   = 4'd7;
    localparam logic [INDEX_W-1:0] POT_FILTER_CUTOFF    = 4'd8;
    localparam logic [INDEX_W-1:0] POT_DELAY_RATE       = 4'd9;
    localparam logic [INDEX_W-1:0] POT_FILTER_QUALITY   = 4'd10;
    localparam logic [INDEX_W-1:0] POT_DELAY_WET        = 4'd11;

endpackage

// File: adc_pkg.sv
package adc_pkg;

    // sclk periods per conversion, cs_n low throughout
    localparam int FRAME_BITS = 16;

    // channel select field on mosi
    localparam int CHAN_W = 4;

    // start bit then channel, msb first
    localparam int CMD_BITS = 1 + CHAN_W;

    // frame bit that carries the start bit
    localparam int START_POS = 0;

    // result sits in frame bits 6..15 on miso, msb first,
    // so the lsb is the final bit of the frame
    localparam int RESULT_LSB_BIT = 15;

endpackage

// File: adc_spi_master.sv
`timescale 1ns/1ps

module adc_spi_master
    import adc_pkg::*;
    import pot_pkg::*;
#(
    parameter int CLK_DIV = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               conv_start,
    input  logic [CHAN_W-1:0]  conv_channel,
    input  logic               miso,
    output logic               busy,
    output logic               conv_done,
    output logic [VALUE_W-1:0] conv_data,
    output logic               sclk,
    output logic               cs_n,
    output logic               mosi
);

    localparam int DIV_W    = $clog2(CLK_DIV + 1);
    localparam int BIT_W    = $clog2(FRAME_BITS);
    localparam int RX_LO    = FRAME_BITS - 1 - RESULT_LSB_BIT;
    localparam int TX_ALIGN = FRAME_BITS - CMD_BITS - START_POS;

    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(FRAME_BITS - 1);

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        DONE
    } state_t;

    state_t                state;
    logic [DIV_W-1:0]      div_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic [FRAME_BITS-1:0] tx_shift;
    logic [FRAME_BITS-1:0] rx_shift;
    logic                  half_tick;

    assign half_tick = (state == SHIFT) && (div_cnt == DIV_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            sclk      <= 1'b0;
            cs_n      <= 1'b1;
            conv_done <= 1'b0;
            tx_shift  <= '0;
        end else begin
            conv_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (conv_start) begin
                        state    <= SHIFT;
                        cs_n     <= 1'b0;
                        div_cnt  <= '0;
                        bit_cnt  <= '0;
                        // start bit lands on mosi together with cs_n
                        tx_shift <= FRAME_BITS'({1'b1, conv_channel}) << TX_ALIGN;
                    end
                end
                SHIFT: begin
                    if (half_tick) begin
                        div_cnt <= '0;
                        sclk    <= ~sclk;
                        if (sclk) begin
                            // falling edge, next command bit
                            tx_shift <= tx_shift << 1;
                            bit_cnt  <= bit_cnt + 1'b1;
                            if (bit_cnt == BIT_LAST) begin
                                state <= DONE;
                            end
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                DONE: begin
                    cs_n      <= 1'b1;
                    conv_done <= 1'b1;
                    state     <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // sample miso as sclk rises
    always_ff @(posedge clk) begin
        if (half_tick && !sclk) begin
            rx_shift <= {rx_shift[FRAME_BITS-2:0], miso};
        end
    end

    assign mosi      = tx_shift[FRAME_BITS-1];
    assign busy      = (state != IDLE);
    assign conv_data = rx_shift[RX_LO +: VALUE_W];

endmodule

// File: pot_scanner.sv
`timescale 1ns/1ps

module pot_scanner
    import pot_pkg::*;
#(
    parameter int SCAN_GAP = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               busy,
    input  logic               conv_done,
    input  logic [VALUE_W-1:0] conv_data,
    output logic               conv_start,
    output logic [INDEX_W-1:0] conv_channel,
    output logic               value_valid,
    output logic [VALUE_W-1:0] value,
    output logic [INDEX_W-1:0] pot_index,
    output logic               sweep_done
);

    localparam int GAP_W = $clog2(SCAN_GAP + 1);

    localparam logic [GAP_W-1:0]   GAP_LAST = GAP_W'(SCAN_GAP - 1);
    localparam logic [INDEX_W-1:0] CH_LAST  = INDEX_W'(NUM_POTS - 1);

    logic             waiting;
    logic [GAP_W-1:0] gap_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            waiting      <= 1'b0;
            gap_cnt      <= '0;
            conv_channel <= '0;
            conv_start   <= 1'b0;
            value_valid  <= 1'b0;
            sweep_done   <= 1'b0;
        end else begin
            conv_start  <= 1'b0;
            value_valid <= 1'b0;
            sweep_done  <= 1'b0;
            if (!waiting) begin
                // idle gap before the next frame
                if (gap_cnt == GAP_LAST) begin
                    if (!busy) begin
                        conv_start <= 1'b1;
                        waiting    <= 1'b1;
                    end
                end else begin
                    gap_cnt <= gap_cnt + 1'b1;
                end
            end else if (conv_done) begin
                value_valid  <= 1'b1;
                sweep_done   <= (conv_channel == CH_LAST);
                conv_channel <= (conv_channel == CH_LAST) ? '0 : conv_channel + 1'b1;
                waiting      <= 1'b0;
                gap_cnt      <= '0;
            end
        end
    end

    // reading tagged with the channel that produced it
    always_ff @(posedge clk) begin
        if (waiting && conv_done) begin
            value     <= conv_data;
            pot_index <= conv_channel;
        end
    end

endmodule

// File: pot_state.sv
`timescale 1ns/1ps

module pot_state
    import pot_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [VALUE_W-1:0] value,
    input  logic [INDEX_W-1:0] pot_index,
    input  logic               value_valid,
    output logic [VALUE_W-1:0] volume,
    output logic [VALUE_W-1:0] pitch,
    output logic [VALUE_W-1:0] delay_wet,
    output logic [VALUE_W-1:0] delay_rate,
    output logic [VALUE_W-1:0] delay_feedback,
    output logic [VALUE_W-1:0] reverb_wet,
    output logic [VALUE_W-1:0] reverb_size,
    output logic [VALUE_W-1:0] reverb_feedback,
    output logic [VALUE_W-1:0] filter_quality,
    output logic [VALUE_W-1:0] filter_cutoff,
    output logic [VALUE_W-1:0] distortion_drive,
    output logic [VALUE_W-1:0] crush_pressure
);

    // rising readings land one below, so a +/-1 flicker settles
    // at the lower code; full scale 0x3FF is never stored
    function automatic logic [VALUE_W-1:0] settle(
        input logic [VALUE_W-1:0] reading,
        input logic [VALUE_W-1:0] current
    );
        return (reading > current) ? reading - 1'b1 : reading;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            volume           <= '0;
            pitch            <= '0;
            delay_wet        <= '0;
            delay_rate       <= '0;
            delay_feedback   <= '0;
            reverb_wet       <= '0;
            reverb_size      <= '0;
            reverb_feedback  <= '0;
            filter_quality   <= '0;
            filter_cutoff    <= '0;
            distortion_drive <= '0;
            crush_pressure   <= '0;
        end else if (value_valid) begin
            case (pot_index)
                POT_VOLUME:           volume           <= settle(value, volume);
                POT_REVERB_FEEDBACK:  reverb_feedback  <= settle(value, reverb_feedback);
                POT_PITCH:            pitch            <= settle(value, pitch);
                POT_REVERB_SIZE:      reverb_size      <= settle(value, reverb_size);
                POT_CRUSH_PRESSURE:   crush_pressure   <= settle(value, crush_pressure);
                POT_REVERB_WET:       reverb_wet       <= settle(value, reverb_wet);
                POT_DISTORTION_DRIVE: distortion_drive <= settle(value, distortion_drive);
                POT_DELAY_FEEDBACK:   delay_feedback   <= settle(value, delay_feedback);
                POT_FILTER_CUTOFF:    filter_cutoff    <= settle(value, filter_cutoff);
                POT_DELAY_RATE:       delay_rate       <= settle(value, delay_rate);
                POT_FILTER_QUALITY:   filter_quality   <= settle(value, filter_quality);
                POT_DELAY_WET:        delay_wet        <= settle(value, delay_wet);
                default: ;
            endcase
        end
    end

endmodule

// File: pot_bank.sv
`timescale 1ns/1ps

module pot_bank
    import pot_pkg::*;
#(
    parameter int CLK_DIV  = 4,
    parameter int SCAN_GAP = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               miso,
    output logic               sclk,
    output logic               cs_n,
    output logic               mosi,
    output logic               sweep_done,
    output logic [VALUE_W-1:0] volume,
    output logic [VALUE_W-1:0] pitch,
    output logic [VALUE_W-1:0] delay_wet,
    output logic [VALUE_W-1:0] delay_rate,
    output logic [VALUE_W-1:0] delay_feedback,
    output logic [VALUE_W-1:0] reverb_wet,
    output logic [VALUE_W-1:0] reverb_size,
    output logic [VALUE_W-1:0] reverb_feedback,
    output logic [VALUE_W-1:0] filter_quality,
    output logic [VALUE_W-1:0] filter_cutoff,
    output logic [VALUE_W-1:0] distortion_drive,
    output logic [VALUE_W-1:0] crush_pressure
);

    // scanner to spi master
    logic               busy;
    logic               conv_start;
    logic [INDEX_W-1:0] conv_channel;
    logic               conv_done;
    logic [VALUE_W-1:0] conv_data;

    // scanner to parameter registers
    logic               value_valid;
    logic [VALUE_W-1:0] value;
    logic [INDEX_W-1:0] pot_index;

    pot_scanner #(
        .SCAN_GAP(SCAN_GAP)
    ) u_scanner (
        .clk         (clk),
        .rst         (rst),
        .busy        (busy),
        .conv_done   (conv_done),
        .conv_data   (conv_data),
        .conv_start  (conv_start),
        .conv_channel(conv_channel),
        .value_valid (value_valid),
        .value       (value),
        .pot_index   (pot_index),
        .sweep_done  (sweep_done)
    );

    adc_spi_master #(
        .CLK_DIV(CLK_DIV)
    ) u_spi (
        .clk         (clk),
        .rst         (rst),
        .conv_start  (conv_start),
        .conv_channel(conv_channel),
        .miso        (miso),
        .busy        (busy),
        .conv_done   (conv_done),
        .conv_data   (conv_data),
        .sclk        (sclk),
        .cs_n        (cs_n),
        .mosi        (mosi)
    );

    pot_state u_state (
        .clk             (clk),
        .rst             (rst),
        .value           (value),
        .pot_index       (pot_index),
        .value_valid     (value_valid),
        .volume          (volume),
        .pitch           (pitch),
        .delay_wet       (delay_wet),
        .delay_rate      (delay_rate),
        .delay_feedback  (delay_feedback),
        .reverb_wet      (reverb_wet),
        .reverb_size     (reverb_size),
        .reverb_feedback (reverb_feedback),
        .filter_quality  (filter_quality),
        .filter_cutoff   (filter_cutoff),
        .distortion_drive(distortion_drive),
        .crush_pressure  (crush_pressure)
    );

endmodule

// File: tb_adc_model.sv
`timescale 1ns/1ps

module tb_adc_model
    import adc_pkg::*;
    import pot_pkg::*;
(
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output logic miso
);

    // per-channel reading, loaded by the testbench
    logic [VALUE_W-1:0] reading [2**CHAN_W] = '{default: '0};

    // frame status for the testbench
    logic [CHAN_W-1:0] last_channel = '0;
    int                cmd_count    = 0;
    int                frame_count  = 0;
    logic              start_err    = 1'b0;
    logic              chan_err     = 1'b0;
    logic              len_err      = 1'b0;

    int                    rise_cnt = 0;
    logic [CMD_BITS-1:0]   cmd      = '0;
    logic [FRAME_BITS-1:0] word;
    logic                  miso_q   = 1'b0;

    assign miso = miso_q;

    // command comes in on rising sclk, length checked as cs_n rises
    always @(posedge sclk or posedge cs_n) begin
        if (cs_n) begin
            if (rise_cnt != 0) begin
                if (rise_cnt != FRAME_BITS) begin
                    len_err = 1'b1;
                end
                frame_count++;
            end
            rise_cnt = 0;
            cmd      = '0;
        end else begin
            if (rise_cnt < CMD_BITS) begin
                cmd = {cmd[CMD_BITS-2:0], mosi};
            end
            rise_cnt++;
            if (rise_cnt == CMD_BITS) begin
                if (!cmd[CMD_BITS-1]) begin
                    start_err = 1'b1;
                end
                if (int'(cmd[CHAN_W-1:0]) >= NUM_POTS) begin
                    chan_err = 1'b1;
                end
                last_channel = cmd[CHAN_W-1:0];
                cmd_count++;
            end
        end
    end

    // frame bit k stays on miso through rising edge k, result in bits 6..15
    always @(negedge sclk or negedge cs_n) begin
        word   = FRAME_BITS'(reading[last_channel]) << rise_cnt;
        miso_q = word[FRAME_BITS-1];
    end

endmodule

// File: tb_pot_bank.sv
`timescale 1ns/1ps

module tb_pot_bank
    import pot_pkg::*;
    import adc_pkg::*;
();

    localparam int CLK_DIV      = 2;
    localparam int SCAN_GAP     = 4;
    localparam int NUM_SWEEPS   = 10;
    localparam int SWEEP_CYCLES = NUM_POTS * (2 * CLK_DIV * FRAME_BITS + 3 + SCAN_GAP);
    localparam int CYCLE_LIMIT  = NUM_SWEEPS * SWEEP_CYCLES * 2;
    localparam logic [31:0] SEED = 32'h98e8_9481;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic miso, sclk, cs_n, mosi, sweep_done;
    logic [VALUE_W-1:0] volume, pitch, delay_wet, delay_rate, delay_feedback, reverb_wet;
    logic [VALUE_W-1:0] reverb_size, reverb_feedback, filter_quality, filter_cutoff;
    logic [VALUE_W-1:0] distortion_drive, crush_pressure;

    logic [VALUE_W-1:0] expected [NUM_POTS];
    logic [VALUE_W-1:0] rd       [NUM_POTS];
    logic [VALUE_W-1:0] jitter_v [NUM_POTS];

    int cycles          = 0;
    int sweeps          = 0;
    int cmds_seen       = 0;
    int next_chan       = 0;
    int frames_at_sweep = 0;

    pot_bank #(
        .CLK_DIV (CLK_DIV),
        .SCAN_GAP(SCAN_GAP)
    ) UUT (
        .clk(clk), .rst(rst), .miso(miso), .sclk(sclk), .cs_n(cs_n), .mosi(mosi),
        .sweep_done(sweep_done), .volume(volume), .pitch(pitch), .delay_wet(delay_wet),
        .delay_rate(delay_rate), .delay_feedback(delay_feedback), .reverb_wet(reverb_wet),
        .reverb_size(reverb_size), .reverb_feedback(reverb_feedback),
        .filter_quality(filter_quality), .filter_cutoff(filter_cutoff),
        .distortion_drive(distortion_drive), .crush_pressure(crush_pressure)
    );

    tb_adc_model adc (.sclk(sclk), .cs_n(cs_n), .mosi(mosi), .miso(miso));

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // rising reading stored one below, anything else stored as is
    function automatic logic [VALUE_W-1:0] next_param(
        input logic [VALUE_W-1:0] reading,
        input logic [VALUE_W-1:0] stored
    );
        if (reading > stored) begin
            return reading - 10'd1;
        end
        return reading;
    endfunction

    function automatic int pick_below(input int n);
        return int'($urandom % n);
    endfunction

    task automatic check_param(input string name, input logic [VALUE_W-1:0] got,
                               input logic [VALUE_W-1:0] want);
        assert (got == want) else abort_run($sformatf(
            "Mismatch at time %0t: %s is %0d, expected %0d", $time, name, got, want));
    endtask

    task automatic check_all;
        check_param("volume",           volume,           expected[POT_VOLUME]);
        check_param("reverb_feedback",  reverb_feedback,  expected[POT_REVERB_FEEDBACK]);
        check_param("pitch",            pitch,            expected[POT_PITCH]);
        check_param("reverb_size",      reverb_size,      expected[POT_REVERB_SIZE]);
        check_param("crush_pressure",   crush_pressure,   expected[POT_CRUSH_PRESSURE]);
        check_param("reverb_wet",       reverb_wet,       expected[POT_REVERB_WET]);
        check_param("distortion_drive", distortion_drive, expected[POT_DISTORTION_DRIVE]);
        check_param("delay_feedback",   delay_feedback,   expected[POT_DELAY_FEEDBACK]);
        check_param("filter_cutoff",    filter_cutoff,    expected[POT_FILTER_CUTOFF]);
        check_param("delay_rate",       delay_rate,       expected[POT_DELAY_RATE]);
        check_param("filter_quality",   filter_quality,   expected[POT_FILTER_QUALITY]);
        check_param("delay_wet",        delay_wet,        expected[POT_DELAY_WET]);
    endtask

    // sweep 0 and 9 distinct, 1 rising, 2..5 jitter, 6..7 falling, 8 zero
    task automatic load_readings(input int sweep);
        for (int ch = 0; ch < NUM_POTS; ch++) begin
            if (sweep == 2) begin
                jitter_v[ch] = 10'(2 + pick_below(1000));
            end
            if (sweep == 0 || sweep == NUM_SWEEPS - 1) begin
                rd[ch] = 10'(ch * 83 + 1 + pick_below(40));
            end else if (sweep == 1) begin
                rd[ch] = 10'(int'(expected[ch]) + 1 + pick_below(1023 - int'(expected[ch])));
            end else if (sweep <= 5) begin
                rd[ch] = (sweep % 2 == 0) ? jitter_v[ch] : jitter_v[ch] - 10'd1;
            end else if (sweep <= 7) begin
                rd[ch] = (expected[ch] == 0) ? '0 : 10'(pick_below(int'(expected[ch])));
            end else begin
                rd[ch] = '0;
            end
        end
        if (sweep == 0) begin
            rd[POT_PITCH] = '0;
        end
        for (int ch = 0; ch < NUM_POTS; ch++) begin
            adc.reading[ch] = rd[ch];
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            abort_run($sformatf("Timeout: only %0d of %0d sweeps finished within %0d cycles",
                                sweeps, NUM_SWEEPS, CYCLE_LIMIT));
        end
    end

    // ADC side: framing, channel order, frames per sweep
    always @(negedge clk) begin
        assert (!adc.start_err) else abort_run("ADC model saw a command without a start bit");
        assert (!adc.chan_err) else abort_run("ADC model was asked for a channel above 11");
        assert (!adc.len_err) else abort_run("ADC model saw a frame of the wrong length");
        if (adc.cmd_count != cmds_seen) begin
            assert (int'(adc.last_channel) == next_chan) else abort_run($sformatf(
                "Mismatch at time %0t: ADC channel %0d, expected %0d",
                $time, adc.last_channel, next_chan));
            cmds_seen = adc.cmd_count;
            next_chan = (next_chan == NUM_POTS - 1) ? 0 : next_chan + 1;
        end
        if (!rst && sweep_done) begin
            assert (adc.frame_count - frames_at_sweep == NUM_POTS) else abort_run($sformatf(
                "Mismatch at time %0t: %0d frames in a sweep, expected %0d",
                $time, adc.frame_count - frames_at_sweep, NUM_POTS));
            frames_at_sweep = adc.frame_count;
        end
    end

    initial begin
        void'($urandom(SEED));
        for (int ch = 0; ch < NUM_POTS; ch++) begin
            expected[ch] = '0;
        end
        load_readings(0);
        repeat (4) @(posedge clk);
        #1 rst = 0;

        // reset state, before any frame
        check_all();
        assert (cs_n === 1'b1) else abort_run($sformatf(
            "Mismatch at time %0t: cs_n is %b after reset", $time, cs_n));
        assert (adc.frame_count == 0) else abort_run("a frame ran before reset ended");

        for (int s = 0; s < NUM_SWEEPS; s++) begin
            do begin
                @(posedge clk);
                #1;
            end while (!sweep_done);
            for (int ch = 0; ch < NUM_POTS; ch++) begin
                expected[ch] = next_param(rd[ch], expected[ch]);
            end
            if (s < NUM_SWEEPS - 1) begin
                load_readings(s + 1);
            end
            // channel 11 lands one edge after sweep_done
            @(posedge clk);
            #1;
            check_all();
            sweeps++;
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: project.f
pot_pkg.sv
adc_pkg.sv
adc_spi_master.sv
pot_scanner.sv
pot_state.sv
pot_bank.sv
tb_adc_model.sv
tb_pot_bank.sv

// File: Makefile
VERILATOR   ?= verilator
FILELIST    ?= project.f
TB_TOP      ?= tb_pot_bank
RTL_TOP     ?= pot_bank
RTL_FILES   ?= pot_pkg.sv adc_pkg.sv adc_spi_master.sv pot_scanner.sv pot_state.sv pot_bank.sv
BUILD_DIR   ?= obj_dir
SIM_BIN     ?= sim_$(TB_TOP)
VFLAGS      ?= --timing --assert
BUILD_FLAGS ?= -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(RTL_FILES) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(BUILD_FLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
